//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_NAME=simGpioSubsystem
LOG_FILE=sim.log

verilator --binary --timing --timescale 1ns/10ps \
    --top-module tbGpioSubsystem \
    --Mdir "$BUILD_DIR" -o "$SIM_NAME" \
    -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_NAME" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see $LOG_FILE"
exit 1

//--- source/busPkg.sv
`default_nettype none

package busPkg;

    // One Avalon slave request as seen in a single clock
    typedef struct packed {
        logic        read;
        logic        write;
        logic [29:0] addr;      // Word address from the master
        logic [3:0]  byteEn;
        logic [31:0] writeData;
    } avReq_t;

    // Register offsets inside the peripheral window
    typedef enum logic [1:0] {
        REG_GPIO_IN  = 2'd0,
        REG_GPIO_OUT = 2'd1,
        REG_GPIO_DDR = 2'd2,
        REG_SEG      = 2'd3
    } regAddr_e;

endpackage

`default_nettype wire

//--- source/displayPkg.sv
`default_nettype none

package displayPkg;

    // Contents of the SEG register
    typedef struct packed {
        logic       hexMode;
        logic [6:0] digit2;
        logic [6:0] digit1;
        logic [6:0] digit0;
    } segDigits_t;

    typedef enum logic [1:0] {
        SCAN_D0 = 2'd0,
        SCAN_D1 = 2'd1,
        SCAN_D2 = 2'd2
    } scanState_e;

    // Segment patterns are gfedcba, a lit segment is 1
    function automatic logic [6:0] hexToSeg(input logic [3:0] value);
        case (value)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C; // Lower case b
            4'hC: return 7'h39;
            4'hD: return 7'h5E; // Lower case d
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/gpioBusInterface.sv
`timescale 1ns/10ps
`default_nettype none

module gpioBusInterface import busPkg::*, displayPkg::*; #(
    parameter int NumGpio       = 16,
    parameter int PeriphSelBits = 5,
    parameter int PeriphSelVal  = 0
) (
    input  wire logic               i_Clk,
    input  wire logic               i_rstN,

    input  wire avReq_t             i_Req,
    output logic [31:0]             o_ReadData,
    output logic                    o_WaitRequest,

    input  wire logic [NumGpio-1:0] i_SyncIn,
    output logic [NumGpio-1:0]      o_OutLatch,
    output logic [NumGpio-1:0]      o_DdrLatch,
    output segDigits_t              o_Digits
);

    localparam logic [PeriphSelBits-1:0] SelVal = PeriphSelBits'(PeriphSelVal);

    logic               slaveSel;
    logic               selRead;
    logic               selWrite;
    regAddr_e           regAddr;
    logic               readPending;
    logic [31:0]        readMux;
    logic [NumGpio-1:0] outLatch;
    logic [NumGpio-1:0] ddrLatch;
    segDigits_t         segReg;

    // Replaces each byte of the old value whose enable is set
    function automatic logic [31:0] laneMerge(
        input logic [31:0] oldVal,
        input logic [31:0] newVal,
        input logic [3:0]  byteEn
    );
        logic [31:0] merged;
        for (int lane = 0; lane < 4; lane++) begin
            merged[lane*8 +: 8] = byteEn[lane] ? newVal[lane*8 +: 8] : oldVal[lane*8 +: 8];
        end
        return merged;
    endfunction

    // Window is the top address bits, the offset bits in between just alias
    assign slaveSel = (i_Req.addr[29 -: PeriphSelBits] == SelVal);
    assign regAddr  = regAddr_e'(i_Req.addr[1:0]);
    assign selRead  = slaveSel & i_Req.read;
    assign selWrite = slaveSel & i_Req.write;

    // First read cycle stalls, the second one returns the registered data
    assign o_WaitRequest = selRead & ~readPending;

    always_comb begin
        case (regAddr)
            REG_GPIO_IN:  readMux = 32'(i_SyncIn);
            REG_GPIO_OUT: readMux = 32'(outLatch);
            REG_GPIO_DDR: readMux = 32'(ddrLatch);
            REG_SEG: begin
                readMux = {7'b0, segReg.hexMode,
                           1'b0, segReg.digit2,
                           1'b0, segReg.digit1,
                           1'b0, segReg.digit0};
            end
            default:      readMux = '0;
        endcase
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            readPending <= 1'b0;
            o_ReadData  <= '0;
        end else begin
            readPending <= selRead & ~readPending;
            o_ReadData  <= (selRead && !readPending) ? readMux : '0; // Idle bus reads back 0
        end
    end

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            outLatch <= '0;
            ddrLatch <= '0;
            segReg   <= '0;
        end else if (selWrite) begin
            case (regAddr)
                REG_GPIO_OUT: begin
                    outLatch <= NumGpio'(laneMerge(32'(outLatch), i_Req.writeData,
                                                   i_Req.byteEn));
                end
                REG_GPIO_DDR: begin
                    ddrLatch <= NumGpio'(laneMerge(32'(ddrLatch), i_Req.writeData,
                                                   i_Req.byteEn));
                end
                REG_SEG: begin
                    if (i_Req.byteEn[0]) segReg.digit0  <= i_Req.writeData[6:0];
                    if (i_Req.byteEn[1]) segReg.digit1  <= i_Req.writeData[14:8];
                    if (i_Req.byteEn[2]) segReg.digit2  <= i_Req.writeData[22:16];
                    if (i_Req.byteEn[3]) segReg.hexMode <= i_Req.writeData[24];
                end
                default: begin
                    // GPIO_IN is read-only
                end
            endcase
        end
    end

    assign o_OutLatch = outLatch;
    assign o_DdrLatch = ddrLatch;
    assign o_Digits   = segReg;

endmodule

`default_nettype wire

//--- source/gpioPort.sv
`timescale 1ns/10ps
`default_nettype none

module gpioPort #(
    parameter int NumGpio = 16
) (
    input  wire logic               i_Clk,
    input  wire logic               i_rstN,

    input  wire logic [NumGpio-1:0] i_GpioIn,
    input  wire logic [NumGpio-1:0] i_OutLatch,
    input  wire logic [NumGpio-1:0] i_DdrLatch,

    output logic [NumGpio-1:0]      o_SyncIn,
    output logic [NumGpio-1:0]      o_GpioOut,
    output logic [NumGpio-1:0]      o_GpioOe
);

    logic [NumGpio-1:0] syncMeta;
    logic [NumGpio-1:0] syncOut;

    // The pins are asynchronous to i_Clk, so two stages settle metastability
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            syncMeta <= '0;
            syncOut  <= '0;
        end else begin
            syncMeta <= i_GpioIn;
            syncOut  <= syncMeta;
        end
    end

    assign o_SyncIn = syncOut;

    // Tri-state buffers sit in the board top and take drive and enable apart
    assign o_GpioOut = i_OutLatch;
    assign o_GpioOe  = i_DdrLatch;  // A set bit drives the pin

endmodule

`default_nettype wire

//--- source/gpioSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module gpioSubsystem import busPkg::*, displayPkg::*; #(
    parameter int NumGpio       = 16,
    parameter int ScanDiv       = 32768,
    parameter int PeriphSelBits = 5,
    parameter int PeriphSelVal  = 0
) (
    input  wire logic               i_Clk,
    input  wire logic               i_rstN,

    // Avalon slave
    input  wire logic [29:0]        i_AvAddr,
    input  wire logic [3:0]         i_AvByteEn,
    input  wire logic               i_AvRead,
    input  wire logic               i_AvWrite,
    input  wire logic [31:0]        i_AvWriteData,
    output logic [31:0]             o_AvReadData,
    output logic                    o_AvWaitRequest,

    input  wire logic [NumGpio-1:0] i_GpioIn,
    output logic [NumGpio-1:0]      o_GpioOut,
    output logic [NumGpio-1:0]      o_GpioOe,

    output logic [2:0]              o_SegEn,
    output logic [6:0]              o_SegLed
);

    avReq_t             avReq;
    segDigits_t         digits;
    logic [NumGpio-1:0] syncIn;
    logic [NumGpio-1:0] outLatch;
    logic [NumGpio-1:0] ddrLatch;
    logic               scanTick;

    assign avReq.read      = i_AvRead;
    assign avReq.write     = i_AvWrite;
    assign avReq.addr      = i_AvAddr;
    assign avReq.byteEn    = i_AvByteEn;
    assign avReq.writeData = i_AvWriteData;

    gpioBusInterface #(
        .NumGpio       (NumGpio),
        .PeriphSelBits (PeriphSelBits),
        .PeriphSelVal  (PeriphSelVal)
    ) u_busIf (
        .i_Clk         (i_Clk),
        .i_rstN        (i_rstN),
        .i_Req         (avReq),
        .o_ReadData    (o_AvReadData),
        .o_WaitRequest (o_AvWaitRequest),
        .i_SyncIn      (syncIn),
        .o_OutLatch    (outLatch),
        .o_DdrLatch    (ddrLatch),
        .o_Digits      (digits)
    );

    gpioPort #(
        .NumGpio    (NumGpio)
    ) u_gpioPort (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .i_GpioIn   (i_GpioIn),
        .i_OutLatch (outLatch),
        .i_DdrLatch (ddrLatch),
        .o_SyncIn   (syncIn),
        .o_GpioOut  (o_GpioOut),
        .o_GpioOe   (o_GpioOe)
    );

    scanTickGen #(
        .ScanDiv    (ScanDiv)
    ) u_scanTick (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .o_ScanTick (scanTick)
    );

    sevenSegDriver u_segDriver (
        .i_Clk      (i_Clk),
        .i_rstN     (i_rstN),
        .i_ScanTick (scanTick),
        .i_Digits   (digits),
        .o_SegEn    (o_SegEn),
        .o_SegLed   (o_SegLed)
    );

endmodule

`default_nettype wire

//--- source/scanTickGen.sv
`timescale 1ns/10ps
`default_nettype none

module scanTickGen #(
    parameter int ScanDiv = 32768
) (
    input  wire logic i_Clk,
    input  wire logic i_rstN,
    output logic      o_ScanTick
);

    localparam int                CntWidth  = $clog2(ScanDiv);
    localparam logic [CntWidth-1:0] LastCount = CntWidth'(ScanDiv - 1);

    logic [CntWidth-1:0] count;

    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            count <= '0;
        end else if (count == LastCount) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // One enable pulse per ScanDiv clocks keeps the display on i_Clk
    assign o_ScanTick = (count == LastCount);

endmodule

`default_nettype wire

//--- source/sevenSegDriver.sv
`timescale 1ns/10ps
`default_nettype none

module sevenSegDriver import displayPkg::*; (
    input  wire logic       i_Clk,
    input  wire logic       i_rstN,

    input  wire logic       i_ScanTick,
    input  wire segDigits_t i_Digits,

    output logic [2:0]      o_SegEn,
    output logic [6:0]      o_SegLed
);

    scanState_e scanState;
    scanState_e nextState;
    logic [6:0] nextField;
    logic [2:0] nextEn;
    logic [6:0] nextLed;

    always_comb begin
        case (scanState)
            SCAN_D0: nextState = SCAN_D1;
            SCAN_D1: nextState = SCAN_D2;
            default: nextState = SCAN_D0;
        endcase
    end

    // Field and enable belong to the digit the scan is about to enter
    always_comb begin
        case (nextState)
            SCAN_D1: begin
                nextField = i_Digits.digit1;
                nextEn    = 3'b010;
            end
            SCAN_D2: begin
                nextField = i_Digits.digit2;
                nextEn    = 3'b100;
            end
            default: begin
                nextField = i_Digits.digit0;
                nextEn    = 3'b001;
            end
        endcase
    end

    assign nextLed = i_Digits.hexMode ? hexToSeg(nextField[3:0]) : nextField;

    // Enable and pattern update in the same clock so no digit ghosts
    always_ff @(posedge i_Clk) begin
        if (!i_rstN) begin
            scanState <= SCAN_D0;
            o_SegEn   <= 3'b001;
            o_SegLed  <= '0;
        end else if (i_ScanTick) begin
            scanState <= nextState;
            o_SegEn   <= nextEn;
            o_SegLed  <= nextLed;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tbGpioSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tbGpioSubsystem import busPkg::*, displayPkg::*; ();

    localparam int NumGpio       = 16;
    localparam int ScanDiv       = 4;
    localparam int PeriphSelBits = 5;
    localparam int PeriphSelVal  = 3;
    localparam int AliasBits     = 30 - PeriphSelBits - 2;
    localparam int MaxWaitCycles = 8;
    localparam int NumTests      = 6;
    localparam int TestBudgetNs  = 2000;

    localparam logic [PeriphSelBits-1:0] SelVal   = PeriphSelBits'(PeriphSelVal);
    localparam logic [31:0]              GpioMask = 32'((64'd1 << NumGpio) - 64'd1);

    logic               clk;
    logic               rstN;
    logic [29:0]        avAddr;
    logic [3:0]         avByteEn;
    logic               avRead;
    logic               avWrite;
    logic [31:0]        avWriteData;
    logic [31:0]        avReadData;
    logic               avWaitRequest;
    logic [NumGpio-1:0] gpioIn;
    logic [NumGpio-1:0] gpioOut;
    logic [NumGpio-1:0] gpioOe;
    logic [2:0]         segEn;
    logic [6:0]         segLed;

    logic [15:0]        lfsrState;
    int                 mismatchCount;
    int                 failureCount;
    logic [31:0]        outModel;   // Expected register contents
    logic [31:0]        ddrModel;
    segDigits_t         segModel;

    gpioSubsystem #(
        .NumGpio         (NumGpio),
        .ScanDiv         (ScanDiv),
        .PeriphSelBits   (PeriphSelBits),
        .PeriphSelVal    (PeriphSelVal)
    ) u_dut (
        .i_Clk           (clk),
        .i_rstN          (rstN),
        .i_AvAddr        (avAddr),
        .i_AvByteEn      (avByteEn),
        .i_AvRead        (avRead),
        .i_AvWrite       (avWrite),
        .i_AvWriteData   (avWriteData),
        .o_AvReadData    (avReadData),
        .o_AvWaitRequest (avWaitRequest),
        .i_GpioIn        (gpioIn),
        .o_GpioOut       (gpioOut),
        .o_GpioOe        (gpioOe),
        .o_SegEn         (segEn),
        .o_SegLed        (segLed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(NumTests * TestBudgetNs);
        $display("Timeout: the tests did not finish within %0d ns", NumTests * TestBudgetNs);
        $display("Finished with errors");
        $finish;
    end

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        logic        outBit;
        value = '0;
        for (int i = 0; i < width; i++) begin
            outBit    = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) lfsrState = lfsrState ^ 16'hB400;
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    function automatic logic [29:0] busAddress(input logic [PeriphSelBits-1:0] window,
                                               input logic [AliasBits-1:0] aliasBits,
                                               input regAddr_e offset);
        return {window, aliasBits, offset};
    endfunction

    function automatic logic [31:0] byteMask(input logic [3:0] byteEn);
        return {{8{byteEn[3]}}, {8{byteEn[2]}}, {8{byteEn[1]}}, {8{byteEn[0]}}};
    endfunction

    function automatic logic [31:0] segReadback(input segDigits_t s);
        return 32'(s.digit0) | (32'(s.digit1) << 8) | (32'(s.digit2) << 16) |
               (32'(s.hexMode) << 24);
    endfunction

    // Reference patterns in gfedcba order
    function automatic logic [6:0] expectedSegments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'hA: return 7'b1110111;
            4'hB: return 7'b1111100;
            4'hC: return 7'b0111001;
            4'hD: return 7'b1011110;
            4'hE: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("** Error [%s] expected %h, actual %h", testName, expected, actual);
        mismatchCount++;
    endtask

    task automatic reportFailure(input string testName, input string what);
        $display("Failure in %s: %s", testName, what);
        failureCount++;
    endtask

    // Bus tasks start on a falling edge and return on one
    task automatic busWrite(input logic [29:0] addr, input logic [31:0] data,
                            input logic [3:0] byteEn, output int cycles);
        avAddr      = addr;
        avWriteData = data;
        avByteEn    = byteEn;
        avWrite     = 1'b1;
        cycles      = 1;
        #1;  // Waitrequest is combinational and settles after the drive
        while (avWaitRequest && cycles < MaxWaitCycles) begin
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);
        avWrite = 1'b0;
    endtask

    task automatic busRead(input logic [29:0] addr, output logic [31:0] data,
                           output int cycles);
        avAddr   = addr;
        avByteEn = 4'hF;
        avRead   = 1'b1;
        cycles   = 1;
        #1;
        while (avWaitRequest && cycles < MaxWaitCycles) begin
            @(negedge clk);
            cycles++;
        end
        data = avReadData;  // Stable until the edge that ends the transfer
        @(negedge clk);
        avRead = 1'b0;
    endtask

    task automatic writeAndCheck(input string testName, input logic [29:0] addr,
                                 input logic [31:0] data, input logic [3:0] byteEn);
        int cycles;
        busWrite(addr, data, byteEn, cycles);
        if (cycles != 1) begin
            reportFailure(testName, $sformatf("write to %h was not accepted at once", addr));
        end
    endtask

    task automatic readAndCheck(input string testName, input logic [29:0] addr,
                                input logic [31:0] expected, input int expectedCycles);
        logic [31:0] data;
        int          cycles;
        busRead(addr, data, cycles);
        if (cycles != expectedCycles) begin
            reportFailure(testName, $sformatf("read at %h took %0d cycles instead of %0d",
                                              addr, cycles, expectedCycles));
        end
        if (data !== expected) reportMismatch(testName, expected, data);
    endtask

    task automatic testResetState();
        string name = "reset state";
        if (gpioOe !== '0) reportMismatch(name, 32'd0, 32'(gpioOe));
        if (gpioOut !== '0) reportMismatch(name, 32'd0, 32'(gpioOut));
        if (segEn !== 3'b001) reportMismatch(name, 32'd1, 32'(segEn));
        if (avWaitRequest !== 1'b0) reportFailure(name, "waitrequest is high after reset");
        readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_OUT), 32'd0, 2);
        readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_DDR), 32'd0, 2);
        readAndCheck(name, busAddress(SelVal, '0, REG_SEG), 32'd0, 2);
    endtask

    task automatic testRegisterReadback();
        string       name = "register readback";
        logic [31:0] data;
        logic [3:0]  byteEn;
        logic [31:0] mask;
        for (int i = 0; i < 8; i++) begin
            data     = randomBits(32);
            byteEn   = 4'(randomBits(4));
            mask     = byteMask(byteEn);
            outModel = ((outModel & ~mask) | (data & mask)) & GpioMask;
            writeAndCheck(name, busAddress(SelVal, '0, REG_GPIO_OUT), data, byteEn);
            data     = randomBits(32);
            byteEn   = 4'(randomBits(4));
            mask     = byteMask(byteEn);
            ddrModel = ((ddrModel & ~mask) | (data & mask)) & GpioMask;
            writeAndCheck(name, busAddress(SelVal, '0, REG_GPIO_DDR), data, byteEn);
            if (32'(gpioOut) !== outModel) reportMismatch(name, outModel, 32'(gpioOut));
            if (32'(gpioOe) !== ddrModel) reportMismatch(name, ddrModel, 32'(gpioOe));
            readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_OUT), outModel, 2);
            readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_DDR), ddrModel, 2);
        end
    endtask

    task automatic testSegPacking();
        string       name = "SEG packing";
        logic [31:0] data;
        for (int lane = 0; lane < 4; lane++) begin
            data = randomBits(32);
            case (lane)
                0: segModel.digit0 = data[6:0];
                1: segModel.digit1 = data[14:8];
                2: segModel.digit2 = data[22:16];
                default: segModel.hexMode = data[24];
            endcase
            writeAndCheck(name, busAddress(SelVal, '0, REG_SEG), data, 4'b0001 << lane);
            readAndCheck(name, busAddress(SelVal, '0, REG_SEG), segReadback(segModel), 2);
        end
        writeAndCheck(name, busAddress(SelVal, '0, REG_GPIO_IN), randomBits(32), 4'hF);
        readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_IN), 32'(gpioIn), 2);
        readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_OUT), outModel, 2);
        readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_DDR), ddrModel, 2);
        readAndCheck(name, busAddress(SelVal, '0, REG_SEG), segReadback(segModel), 2);
    endtask

    task automatic testInputPath();
        string       name = "input path";
        logic [31:0] pins;
        for (int i = 0; i < 4; i++) begin
            pins   = randomBits(32);
            gpioIn = NumGpio'(pins);
            repeat (3) @(negedge clk);  // Two synchronizer stages plus margin
            readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_IN), pins & GpioMask, 2);
        end
    endtask

    task automatic testAddressWindow();
        string                    name = "address window";
        logic [PeriphSelBits-1:0] window;
        logic [AliasBits-1:0]     aliasBits;
        logic [31:0]              data;
        for (int i = 0; i < 3; i++) begin
            window    = PeriphSelBits'(randomBits(PeriphSelBits));
            aliasBits = AliasBits'(randomBits(AliasBits));
            if (window == SelVal) window = ~SelVal;
            writeAndCheck(name, busAddress(window, aliasBits, REG_GPIO_OUT), randomBits(32), 4'hF);
            writeAndCheck(name, busAddress(window, aliasBits, REG_GPIO_DDR), randomBits(32), 4'hF);
            writeAndCheck(name, busAddress(window, aliasBits, REG_SEG), randomBits(32), 4'hF);
            readAndCheck(name, busAddress(window, aliasBits, REG_GPIO_OUT), 32'd0, 1);
            readAndCheck(name, busAddress(window, aliasBits, REG_SEG), 32'd0, 1);
        end
        if (32'(gpioOut) !== outModel) reportMismatch(name, outModel, 32'(gpioOut));
        readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_OUT), outModel, 2);
        readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_DDR), ddrModel, 2);
        readAndCheck(name, busAddress(SelVal, '0, REG_SEG), segReadback(segModel), 2);
        // Offset bits between the window and the register index only alias
        data      = randomBits(32);
        aliasBits = AliasBits'(randomBits(AliasBits));
        outModel  = data & GpioMask;
        writeAndCheck(name, busAddress(SelVal, aliasBits, REG_GPIO_OUT), data, 4'hF);
        readAndCheck(name, busAddress(SelVal, '0, REG_GPIO_OUT), outModel, 2);
        readAndCheck(name, busAddress(SelVal, ~aliasBits, REG_GPIO_OUT), outModel, 2);
    endtask

    task automatic testDisplayScan();
        string      name = "display scan";
        logic [2:0] prevEn;
        logic [2:0] expEn;
        logic [6:0] field;
        logic [6:0] expLed;
        int         waitCycles;
        for (int mode = 0; mode < 2; mode++) begin
            segModel.digit0  = 7'(randomBits(7));
            segModel.digit1  = 7'(randomBits(7));
            segModel.digit2  = 7'(randomBits(7));
            segModel.hexMode = (mode == 1);
            writeAndCheck(name, busAddress(SelVal, '0, REG_SEG), segReadback(segModel), 4'hF);
            prevEn = segEn;
            for (int step = 0; step < 6; step++) begin  // Two full rotations
                waitCycles = 0;
                while (segEn === prevEn && waitCycles < 4 * ScanDiv) begin
                    @(negedge clk);
                    waitCycles++;
                end
                if (segEn === prevEn) begin
                    reportFailure(name, "the digit enable stopped changing");
                    return;
                end
                expEn = {prevEn[1:0], prevEn[2]};
                case (expEn)
                    3'b010:  field = segModel.digit1;
                    3'b100:  field = segModel.digit2;
                    default: field = segModel.digit0;
                endcase
                expLed = segModel.hexMode ? expectedSegments(field[3:0]) : field;
                if (segEn !== expEn) reportMismatch(name, 32'(expEn), 32'(segEn));
                if (segLed !== expLed) reportMismatch(name, 32'(expLed), 32'(segLed));
                prevEn = segEn;
            end
        end
    endtask

    initial begin
        lfsrState     = 16'd28438;
        mismatchCount = 0;
        failureCount  = 0;
        outModel      = '0;
        ddrModel      = '0;
        segModel      = '0;
        rstN          = 1'b0;
        avAddr        = '0;
        avByteEn      = '0;
        avRead        = 1'b0;
        avWrite       = 1'b0;
        avWriteData   = '0;
        gpioIn        = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        testResetState();
        testRegisterReadback();
        testSegPacking();
        testInputPath();
        testAddressWindow();
        testDisplayScan();

        $display("Value mismatches: %0d, other failures: %0d", mismatchCount, failureCount);
        if (mismatchCount == 0 && failureCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/busPkg.sv
source/displayPkg.sv
source/gpioPort.sv
source/scanTickGen.sv
source/sevenSegDriver.sv
source/gpioBusInterface.sv
source/gpioSubsystem.sv
testbench/tbGpioSubsystem.sv
